// ==== cache_set.sv ====
`default_nettype none

module cache_set
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input wire logic  i_clock,   // System clock
    input wire logic  i_rst_n,   // Sync reset, active low
    cache_set_if.set  bus        // Lookup, write and clear port
);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    logic [CACHE_SIZE-1:0] valid_q;                          // One bit per line
    tag_t                  tag_mem  [CACHE_SIZE];            // Stored tag per line
    inst_t                 data_mem [CACHE_SIZE][BLOCK_SIZE];  // Block words

    tag_t   stored_tag;   // Tag of indexed line
    logic   line_valid;   // Valid of indexed line

    // ------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            valid_q <= '0;                        // Nothing cached
        end else if (bus.clear) begin
            valid_q[bus.index] <= 1'b0;           // Sweep step
        end else if (bus.write) begin
            valid_q[bus.index] <= 1'b1;           // Line being filled
        end
    end

    // ------------------------------------------------------------
    // Tag and data arrays
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (bus.write) begin
            tag_mem[bus.index]              <= bus.tag;    // Same tag on every word
            data_mem[bus.index][bus.offset] <= bus.wdata;  // One word per write
        end
    end

    // Combinational lookup, zero cycle hit path
    assign stored_tag = tag_mem[bus.index];
    assign line_valid = valid_q[bus.index];

    assign bus.hit   = line_valid && (stored_tag == bus.tag);   // Match on valid line
    assign bus.rdata = data_mem[bus.index][bus.offset];         // Addressed word

endmodule

`default_nettype wire

// ==== cache_set_if.sv ====
`default_nettype none

interface cache_set_if
    import icache_types_pkg::*;
();

    tag_t    tag;            // Lookup or write tag
    index_t  index;          // Line select
    offset_t offset;         // Word select seen by the arrays
    logic    write;          // Store wdata at index/offset
    logic    clear;          // Drop valid of indexed line
    inst_t   wdata;          // Word from memory
    inst_t   rdata;          // Word read from the arrays
    logic    hit;            // Tag match on a valid line

    // Offset sources, picked by the controller state
    offset_t lookup_offset;  // CPU word offset
    offset_t refill_offset;  // Word counter of the refill engine
    logic    refill_sel;     // High while refilling

    assign offset = refill_sel ? refill_offset : lookup_offset;  // Single driver path

    modport ctrl   (output tag, index, clear, lookup_offset, refill_sel, input hit);
    modport refill (output refill_offset, write, wdata, input tag, index);
    modport set    (input tag, index, offset, write, clear, wdata, output rdata, hit);

endinterface

`default_nettype wire

// ==== icache.sv ====
`default_nettype none

module icache
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input wire logic        i_clock,   // System clock
    input wire logic        i_rst_n,   // Sync reset, active low

    // CPU fetch port
    input wire inst_addr_t  i_addr,    // Byte address of the instruction
    input wire logic        i_rd,      // Read request
    output inst_t           o_inst,    // Instruction on hit
    output logic            o_busy,    // Miss or clear in progress
    output logic            o_hit,     // Instruction available

    // Wishbone classic to main memory
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output inst_addr_t      o_wb_adr,
    input wire inst_t       i_wb_dat,
    input wire logic        i_wb_ack
);

    tag_t    cpu_tag;       // Address fields
    index_t  cpu_index;
    offset_t cpu_offset;
    logic    refill_start;  // Controller to refill engine
    logic    refill_done;   // Refill engine to controller

    // Byte address to word fields
    assign cpu_tag    = i_addr[2+OFFSET_WIDTH+INDEX_WIDTH +: TAG_WIDTH];
    assign cpu_index  = i_addr[2+OFFSET_WIDTH +: INDEX_WIDTH];
    assign cpu_offset = i_addr[2 +: OFFSET_WIDTH];

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------

    cache_set_if set_bus ();

    icache_ctrl u_ctrl (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_tag          (cpu_tag),
        .i_index        (cpu_index),
        .i_offset       (cpu_offset),
        .i_rd           (i_rd),
        .o_busy         (o_busy),
        .o_hit          (o_hit),
        .o_refill_start (refill_start),
        .i_refill_done  (refill_done),
        .bus            (set_bus.ctrl));

    cache_set u_set (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .bus     (set_bus.set));

    wb_refill u_refill (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_start  (refill_start),
        .o_done   (refill_done),
        .bus      (set_bus.refill),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_adr (o_wb_adr),
        .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack));

    assign o_inst = set_bus.rdata;   // Word selected by the lookup

endmodule

`default_nettype wire

// ==== icache_cfg_pkg.sv ====
`default_nettype none

package icache_cfg_pkg;

    // ------------------------------------------------------------
    // Cache geometry
    // ------------------------------------------------------------

    localparam int unsigned CACHE_SIZE = 128;  // Lines in the single way
    localparam int unsigned BLOCK_SIZE = 4;    // Words per line

    // ------------------------------------------------------------
    // Address fields
    // ------------------------------------------------------------

    localparam int unsigned ADDR_WIDTH   = 32;                    // Byte address bits
    localparam int unsigned INDEX_WIDTH  = $clog2(CACHE_SIZE);    // Line select
    localparam int unsigned OFFSET_WIDTH = $clog2(BLOCK_SIZE);    // Word in line

    // Two low bits select the byte in a word and are dropped
    localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - 2 - INDEX_WIDTH - OFFSET_WIDTH;

endpackage

`default_nettype wire

// ==== icache_checker.sv ====
`default_nettype none

module icache_checker
    import icache_types_pkg::*;
(
    input wire logic         i_clock,   // Cache clock
    input wire logic         i_rst_n,   // Sync reset, active low
    input wire logic         i_hit,     // CPU hit
    input wire logic         i_busy,    // CPU busy
    input wire logic         i_wb_cyc,  // Wishbone cycle
    input wire logic         i_wb_stb,  // Wishbone strobe
    input wire inst_addr_t   i_wb_adr,  // Wishbone address
    input wire logic         i_wb_ack,  // Wishbone acknowledge
    input wire ctrl_state_e  i_state    // Controller state
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // ------------------------------------------------------------
    // Wishbone classic handshake
    // ------------------------------------------------------------

    stb_needs_cyc: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_wb_stb |-> i_wb_cyc)
        else begin
            fail_count++;
            $error("Wishbone strobe high without cycle");
        end

    // Address held until the slave answers
    adr_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_wb_stb && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr)))
        else begin
            fail_count++;
            $error("Wishbone address or strobe changed before ack");
        end

    // ------------------------------------------------------------
    // CPU side and clear sweep
    // ------------------------------------------------------------

    hit_not_busy: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_hit && i_busy))
        else begin
            fail_count++;
            $error("Hit and busy high together");
        end

    no_bus_in_clear: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_state == CLEAR) |-> !i_wb_cyc)
        else begin
            fail_count++;
            $error("Wishbone cycle during the clear sweep");
        end

endmodule

bind icache icache_checker chk (
    .i_clock  (i_clock),
    .i_rst_n  (i_rst_n),
    .i_hit    (o_hit),
    .i_busy   (o_busy),
    .i_wb_cyc (o_wb_cyc),
    .i_wb_stb (o_wb_stb),
    .i_wb_adr (o_wb_adr),
    .i_wb_ack (i_wb_ack),
    .i_state  (u_ctrl.state));

`default_nettype wire

// ==== icache_ctrl.sv ====
`default_nettype none

module icache_ctrl
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input wire logic     i_clock,         // System clock
    input wire logic     i_rst_n,         // Sync reset, active low

    // CPU request fields
    input wire tag_t     i_tag,           // Tag of request
    input wire index_t   i_index,         // Index of request
    input wire offset_t  i_offset,        // Word offset of request
    input wire logic     i_rd,            // Read request
    output logic         o_busy,          // Request not served yet
    output logic         o_hit,           // o_inst valid

    // Refill engine handshake
    output logic         o_refill_start,  // One cycle start pulse
    input wire logic     i_refill_done,   // Last word written

    cache_set_if.ctrl    bus              // Drives the arrays
);

    ctrl_state_e state;       // Current state
    index_t      sweep_idx;   // Clear sweep counter
    tag_t        req_tag;     // Held tag during refill
    index_t      req_index;   // Held index during refill
    logic        miss;        // Lookup request that misses

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state     <= CLEAR;
            sweep_idx <= '0;
        end else begin
            case (state)
                CLEAR: begin
                    sweep_idx <= sweep_idx + 1'b1;                  // Wraps to 0 at the end
                    if (sweep_idx == index_t'(CACHE_SIZE - 1)) begin
                        state <= LOOKUP;                            // Every line cleared
                    end
                end
                LOOKUP: begin
                    if (miss) begin
                        state <= REFILL;                            // Fetch block
                    end
                end
                REFILL: begin
                    if (i_refill_done) begin
                        state <= LOOKUP;                            // Line now valid
                    end
                end
                default: state <= CLEAR;
            endcase
        end
    end

    // Request fields, frozen once the refill starts
    always_ff @(posedge i_clock) begin
        if (state == LOOKUP) begin
            req_tag   <= i_tag;
            req_index <= i_index;
        end
    end

    // ------------------------------------------------------------
    // Array control
    // ------------------------------------------------------------

    assign bus.clear         = (state == CLEAR);
    assign bus.refill_sel    = (state == REFILL);   // Refill engine owns offset
    assign bus.lookup_offset = i_offset;
    assign bus.tag           = (state == REFILL) ? req_tag : i_tag;

    always_comb begin
        case (state)
            CLEAR:   bus.index = sweep_idx;   // Sweep address
            REFILL:  bus.index = req_index;   // Line being filled
            default: bus.index = i_index;     // CPU index
        endcase
    end

    // ------------------------------------------------------------
    // CPU handshake
    // ------------------------------------------------------------

    assign miss           = (state == LOOKUP) && i_rd && !bus.hit;
    assign o_refill_start = miss;                             // Single cycle, state leaves LOOKUP

    assign o_hit  = i_rd && (state == LOOKUP) && bus.hit;
    assign o_busy = i_rd && ((state != LOOKUP) || !bus.hit);  // Never with o_hit

endmodule

`default_nettype wire

// ==== icache_types_pkg.sv ====
`default_nettype none

package icache_types_pkg;

    import icache_cfg_pkg::*;

    // ------------------------------------------------------------
    // Bus words
    // ------------------------------------------------------------

    typedef logic [ADDR_WIDTH-1:0]   inst_addr_t;  // Byte address
    typedef logic [31:0]             inst_t;       // Instruction word

    // Fields of a cache address
    typedef logic [TAG_WIDTH-1:0]    tag_t;        // Upper bits
    typedef logic [INDEX_WIDTH-1:0]  index_t;      // Line number
    typedef logic [OFFSET_WIDTH-1:0] offset_t;     // Word in block

    // ------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        CLEAR  = 2'd0,  // Invalidate sweep after reset
        LOOKUP = 2'd1,  // Normal hit path
        REFILL = 2'd2   // Block fetch in progress
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_icache -f tb.f -o tb_icache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

// ==== tb.f ====
icache_cfg_pkg.sv
icache_types_pkg.sv
cache_set_if.sv
cache_set.sv
icache_ctrl.sv
wb_refill.sv
icache.sv
icache_checker.sv
tb_clock.sv
tb_icache.sv

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic o_clock  // Free running testbench clock
);

    // ------------------------------------------------------------
    // Period of 40 time units
    // ------------------------------------------------------------

    initial begin
        o_clock = 1'b0;  // Known level at time zero
    end

    always #20 o_clock = ~o_clock;  // Half period

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`default_nettype none

module tb_icache
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
();

    localparam int          N_RANDOM    = 300;   // Random reads
    localparam int          N_DIRECTED  = 12;    // Directed reads, rounded up
    localparam int          WORD_CYCLES = 6;     // Strobe, 3 waits, ack, gap
    localparam int          MAX_CYCLES  =
        2 * ((N_RANDOM + N_DIRECTED) * BLOCK_SIZE * WORD_CYCLES + CACHE_SIZE) + 100;
    localparam logic [31:0] BLOCK_BYTES = 32'(BLOCK_SIZE * 4);
    localparam logic [31:0] WAY_BYTES   = 32'(CACHE_SIZE * BLOCK_SIZE * 4);  // Same index
    localparam logic [31:0] RAND_BASE   = 32'h0001_0400;

    logic       i_clock;
    logic       i_rst_n;
    inst_addr_t i_addr;
    logic       i_rd;
    inst_t      o_inst;
    logic       o_busy;
    logic       o_hit;
    logic       o_wb_cyc;
    logic       o_wb_stb;
    inst_addr_t o_wb_adr;
    inst_t      i_wb_dat;
    logic       i_wb_ack;

    logic        shadow_valid [CACHE_SIZE];  // Expected valid per line
    tag_t        shadow_tag   [CACHE_SIZE];  // Expected tag per line
    inst_addr_t  wb_addrs[$];                // Acked addresses of one request
    int unsigned total_reads  = 0;
    int unsigned refill_count = 0;           // Last words acked
    int unsigned exp_misses   = 0;
    int unsigned cycle_count  = 0;
    integer      seed         = 15157;
    int          ack_wait;                   // Wait cycles left on a strobe
    logic        ack_armed;                  // Delay drawn for this strobe
    string       test_name    = "reset";

    tb_clock u_clk (.o_clock(i_clock));

    icache dut (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_addr   (i_addr),
        .i_rd     (i_rd),
        .o_inst   (o_inst),
        .o_busy   (o_busy),
        .o_hit    (o_hit),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_adr (o_wb_adr),
        .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack));

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // Memory content as a hash of the word address
    function automatic inst_t ref_word(input inst_addr_t addr);
        inst_addr_t w;
        inst_t      mix;
        begin
            w   = {addr[ADDR_WIDTH-1:2], 2'b00};
            mix = w * 32'h9E37_79B1;
            mix = mix ^ (mix >> 15) ^ (w << 3) ^ 32'h5A5A_C3C3;
            return mix;
        end
    endfunction

    function automatic tag_t tag_of(input inst_addr_t addr);
        return addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    endfunction

    function automatic index_t index_of(input inst_addr_t addr);
        return addr[2+OFFSET_WIDTH +: INDEX_WIDTH];
    endfunction

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------
    // Memory model, Wishbone classic slave
    // ------------------------------------------------------------

    always @(negedge i_clock) begin
        if (!i_rst_n) begin
            i_wb_ack  = 1'b0;
            ack_armed = 1'b0;
        end else if (i_wb_ack) begin
            i_wb_ack = 1'b0;                                   // Ack lasts one cycle
        end else if (o_wb_stb) begin
            if (!ack_armed) begin
                ack_wait  = int'($unsigned($random(seed)) % 4);  // 0 to 3 waits
                ack_armed = 1'b1;
            end
            if (ack_wait == 0) begin
                i_wb_ack  = 1'b1;
                i_wb_dat  = ref_word(o_wb_adr);
                ack_armed = 1'b0;
                wb_addrs.push_back(o_wb_adr);
                total_reads++;
                if (o_wb_adr[2 +: OFFSET_WIDTH] == offset_t'(BLOCK_SIZE - 1)) begin
                    refill_count++;                            // Block complete
                end
            end else begin
                ack_wait--;
            end
        end
    end

    // ------------------------------------------------------------
    // Compare and timeout
    // ------------------------------------------------------------

    always @(posedge i_clock) begin
        if (i_rst_n && o_hit) begin
            check_value("hit word", ref_word(i_addr), o_inst);  // Every served word
        end
        if (dut.chk.fail_count != 0) begin
            $display("A bound assertion on the cache handshakes failed");
            stop_run();
        end
    end

    always @(posedge i_clock) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    // ------------------------------------------------------------
    // One CPU read, predicted from the shadow table
    // ------------------------------------------------------------

    task automatic read_word(input inst_addr_t addr, output int busy_cycles);
        tag_t       t;
        index_t     idx;
        logic       exp_hit;
        inst_addr_t base;
        int         k;
        begin
            t       = tag_of(addr);
            idx     = index_of(addr);
            exp_hit = shadow_valid[idx] && (shadow_tag[idx] == t);
            base    = {addr[ADDR_WIDTH-1:2+OFFSET_WIDTH], {(OFFSET_WIDTH+2){1'b0}}};
            @(negedge i_clock);
            wb_addrs.delete();
            i_addr      = addr;
            i_rd        = 1'b1;
            busy_cycles = 0;
            @(posedge i_clock);
            check_value("hit in request cycle", 32'(exp_hit), 32'(o_hit));
            check_value("busy in request cycle", 32'(!exp_hit), 32'(o_busy));
            while (!o_hit) begin
                busy_cycles++;
                @(posedge i_clock);
            end
            if (exp_hit) begin
                @(negedge i_clock);
                check_value("no bus on hit", 32'd0, 32'(o_wb_cyc));  // No refill started
            end else begin
                check_value("reads on miss", 32'(BLOCK_SIZE), 32'(wb_addrs.size()));
                for (k = 0; k < BLOCK_SIZE; k++) begin
                    check_value("refill address", base + 32'(k * 4), wb_addrs[k]);  // Ascending
                end
                shadow_valid[idx] = 1'b1;
                shadow_tag[idx]   = t;
                exp_misses++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin : stimulus
        int         n;
        int         bc;
        inst_addr_t a0;
        inst_addr_t addr;
        i_rst_n   = 1'b0;
        i_rd      = 1'b0;
        i_addr    = '0;
        i_wb_ack  = 1'b0;
        i_wb_dat  = '0;
        ack_armed = 1'b0;
        ack_wait  = 0;
        for (n = 0; n < CACHE_SIZE; n++) begin
            shadow_valid[n] = 1'b0;
            shadow_tag[n]   = '0;
        end
        a0 = 32'h0000_2A30;
        repeat (4) begin
            @(negedge i_clock);
            check_value("idle in reset", 32'd0, {28'd0, o_wb_cyc, o_wb_stb, o_busy, o_hit});
        end
        i_rst_n = 1'b1;
        @(negedge i_clock);
        check_value("idle after reset", 32'd0, {28'd0, o_wb_cyc, o_wb_stb, o_busy, o_hit});

        test_name = "clear_then_miss";
        read_word(a0, bc);
        check_value("busy through clear", 32'd1, 32'(bc >= CACHE_SIZE));

        test_name = "same_block_hit";
        for (n = 0; n < BLOCK_SIZE; n++) begin
            read_word({a0[31:4], 4'h0} + 32'(n * 4), bc);
        end

        test_name = "miss_addresses";
        read_word(32'h0000_5178, bc);  // Offset 2, block still fetched from word 0

        test_name = "evict_and_return";
        read_word(a0 + WAY_BYTES, bc);    // Same index, other tag
        read_word(a0, bc);                // Misses again
        read_word(a0 + 32'd4, bc);        // Line back in place

        test_name = "random_window";
        for (n = 0; n < N_RANDOM; n++) begin
            addr = RAND_BASE
                 + ($unsigned($random(seed)) % 3) * WAY_BYTES
                 + ($unsigned($random(seed)) % 6) * BLOCK_BYTES
                 + ($unsigned($random(seed)) % 4) * 32'd4;
            read_word(addr, bc);
        end

        @(negedge i_clock);
        i_rd = 1'b0;
        repeat (2) @(posedge i_clock);
        test_name = "refill_count";
        if ((refill_count == exp_misses) && (total_reads == exp_misses * BLOCK_SIZE)) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("MISMATCH %s: expected %0d, actual %0d",
                     test_name, exp_misses, refill_count);
            stop_run();
        end
    end

endmodule

`default_nettype wire

// ==== wb_refill.sv ====
`default_nettype none

module wb_refill
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input wire logic        i_clock,   // System clock
    input wire logic        i_rst_n,   // Sync reset, active low
    input wire logic        i_start,   // Begin block fetch
    output logic            o_done,    // Ack of the last word
    cache_set_if.refill     bus,       // Write side of the arrays

    // Wishbone classic master
    output logic            o_wb_cyc,  // Bus cycle
    output logic            o_wb_stb,  // Strobe
    output inst_addr_t      o_wb_adr,  // Word aligned byte address
    input wire inst_t       i_wb_dat,  // Read data
    input wire logic        i_wb_ack   // Slave acknowledge
);

    logic    active;      // Block fetch running
    logic    stb_q;       // Strobe and cycle
    offset_t word_cnt;    // Current word of the block
    tag_t    tag_q;       // Block tag
    index_t  index_q;     // Block index
    logic    word_ack;    // Strobe acknowledged
    logic    last_word;   // Counter at block end

    assign word_ack  = stb_q && i_wb_ack;
    assign last_word = (word_cnt == offset_t'(BLOCK_SIZE - 1));

    // ------------------------------------------------------------
    // Word sequencer
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            active   <= 1'b0;
            stb_q    <= 1'b0;
            word_cnt <= '0;
        end else if (i_start) begin
            active   <= 1'b1;
            stb_q    <= 1'b1;                  // First word right away
            word_cnt <= '0;
        end else if (word_ack) begin
            stb_q <= 1'b0;                     // Gap cycle between words
            if (last_word) begin
                active <= 1'b0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end else if (active && !stb_q) begin
            stb_q <= 1'b1;                     // Next classic cycle
        end
    end

    // Block address, taken from the controller on start
    always_ff @(posedge i_clock) begin
        if (i_start) begin
            tag_q   <= bus.tag;
            index_q <= bus.index;
        end
    end

    assign o_wb_cyc = stb_q;                            // Rises and falls with stb
    assign o_wb_stb = stb_q;
    assign o_wb_adr = {tag_q, index_q, word_cnt, 2'b00};

    // Each acknowledged word goes straight into the set
    assign bus.write         = word_ack;
    assign bus.wdata         = i_wb_dat;
    assign bus.refill_offset = word_cnt;
    assign o_done            = word_ack && last_word;

endmodule

`default_nettype wire
